// File: all.f
+incdir+src
src/icache_pkg.sv
src/ic_storage.sv
src/ic_tag_match.sv
src/ic_refill.sv
src/ic_sweep.sv
src/ic_fetch_ctrl.sv
src/icache_top.sv
verif/tb_icache_mem.sv
verif/tb_icache.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_icache -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build returned status $status"
  exit "$status"
fi

./obj_dir/Vtb_icache
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation returned status $status"
  exit "$status"
fi

exit 0

// File: src/ic_fetch_ctrl.sv
// Fetch request FSM, array read issue, memory request and CPU responses
`default_nettype none
`include "icache_macros.svh"

module ic_fetch_ctrl (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  req_valid_i,
  input  wire logic [63:0]           req_pc_i,
  input  wire logic                  req_flush_i,
  input  wire icache_pkg::way_mask_t hit_i,
  input  wire icache_pkg::way_idx_t  way_i,
  input  wire icache_pkg::dword_t    rd_data_i [1 << `IC_WAYS_WIDTH],
  input  wire logic                  sweep_done_i,
  input  wire logic                  sweep_busy_i,
  input  wire logic                  mem_a_ready_i,
  input  wire logic                  refill_last_i,
  input  wire logic                  refill_denied_i,
  output logic                       resp_valid_o,
  output icache_pkg::instr_t         resp_instr_o,
  output logic                       resp_exception_o,
  output icache_pkg::exc_cause_e     resp_ex_code_o,
  output logic                       rd_req_o,
  output icache_pkg::ic_addr_u       addr_o,
  output logic                       advance_o,
  output logic                       refill_start_o,
  output logic                       sweep_start_o,
  output logic                       refill_holds_o,
  output logic                       mem_a_valid_o,
  output icache_pkg::paddr_t         mem_a_address_o
);
  import icache_pkg::*;

  typedef enum logic [2:0] {
    StIdle,
    StFetch,
    StReplay,
    StFill,
    StFlush,
    StExc
  } state_e;

  state_e   state_q, state_d;
  ic_addr_u addr_q, addr_d;
  logic     req_sent_q, req_sent_d;
  logic     canonical;
  dword_t   hit_beat;

  // Upper bits including the top physical bit must be clear
  assign canonical = ~|req_pc_i[63:`IC_PADDR_LEN-1];

  // Next address drives the array read and, once stable, the compare
  assign addr_o = addr_d;

  //////////////////////////////////////////////////
  // Responses and memory request
  //////////////////////////////////////////////////

  assign hit_beat         = rd_data_i[way_i];
  assign resp_instr_o     = addr_q.fields.half ? hit_beat[63:32] : hit_beat[31:0];
  assign resp_exception_o = (state_q == StExc);
  assign resp_ex_code_o   = resp_exception_o ? ExcInstrAccessFault : ExcNone;

  assign refill_holds_o  = (state_q == StFill);
  assign mem_a_valid_o   = (state_q == StFill) && !req_sent_q;
  assign mem_a_address_o = {addr_q.raw[`IC_PADDR_LEN-1:`IC_LINE_OFFSET],
                            {`IC_LINE_OFFSET{1'b0}}};

  //////////////////////////////////////////////////
  // Request FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    addr_d         = addr_q;
    req_sent_d     = req_sent_q;
    resp_valid_o   = 1'b0;
    rd_req_o       = 1'b0;
    advance_o      = 1'b0;
    refill_start_o = 1'b0;
    sweep_start_o  = 1'b0;

    case (state_q)
      StFetch: begin
        if (|hit_i) begin
          resp_valid_o = 1'b1;
          state_d      = StIdle;
        end else begin
          // Refill latches the victim before the pointer moves
          advance_o      = 1'b1;
          refill_start_o = 1'b1;
          req_sent_d     = 1'b0;
          state_d        = StFill;
        end
      end
      StReplay: begin
        rd_req_o = 1'b1;
        state_d  = StFetch;
      end
      StFill: begin
        if (mem_a_valid_o && mem_a_ready_i) begin
          req_sent_d = 1'b1;
        end
        if (refill_last_i) begin
          state_d = refill_denied_i ? StExc : StReplay;
        end
      end
      StFlush: begin
        if (sweep_done_i) begin
          state_d = StReplay;
        end
      end
      StExc: begin
        resp_valid_o = 1'b1;
        state_d      = StIdle;
      end
      default: ;
    endcase

    if (req_valid_i) begin
      addr_d.raw = req_pc_i[`IC_PADDR_LEN-1:0];
      if (!canonical) begin
        state_d = StExc;
      end else if (req_flush_i) begin
        sweep_start_o = 1'b1;
        state_d       = StFlush;
      end else if (sweep_busy_i) begin
        // Wait out the sweep, then replay
        state_d = StFlush;
      end else begin
        rd_req_o = 1'b1;
        state_d  = StFetch;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= StIdle;
      req_sent_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      req_sent_q <= req_sent_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
  end

endmodule

`default_nettype wire

// File: src/ic_refill.sv
// Grant beat counter that writes a refilled line into the chosen way
`default_nettype none
`include "icache_macros.svh"

module ic_refill (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   start_i,
  input  wire icache_pkg::ic_addr_u   line_i,
  input  wire icache_pkg::way_idx_t   way_i,
  input  wire logic                   mem_d_valid_i,
  input  wire icache_pkg::dword_t     mem_d_data_i,
  input  wire logic                   mem_d_denied_i,
  output logic                        mem_d_ready_o,
  output icache_pkg::way_mask_t       wr_ways_o,
  output icache_pkg::set_idx_t        wr_set_o,
  output icache_pkg::beat_idx_t       wr_beat_o,
  output logic                        wr_tag_en_o,
  output logic                        wr_data_en_o,
  output icache_pkg::tag_entry_t      wr_tag_o,
  output icache_pkg::dword_t          wr_data_o,
  output logic                        last_o,
  output logic                        denied_o
);
  import icache_pkg::*;

  logic      active_q;
  logic      beat_fire;
  beat_idx_t beat_q;
  way_idx_t  way_q;

  assign mem_d_ready_o = active_q;
  assign beat_fire     = active_q && mem_d_valid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      beat_q   <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      beat_q   <= '0;
    end else if (beat_fire) begin
      beat_q <= beat_q + 1'b1;
      if (&beat_q) begin
        active_q <= 1'b0;
      end
    end
  end

  // Victim pointer moves on start, so keep the way chosen at that time
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      way_q <= way_i;
    end
  end

  assign wr_ways_o    = way_mask_t'(1) << way_q;
  assign wr_set_o     = line_i.fields.set_idx;
  assign wr_beat_o    = beat_q;
  assign wr_data_o    = mem_d_data_i;
  assign wr_data_en_o = beat_fire && !mem_d_denied_i;

  // Tag becomes valid only with the final beat
  assign last_o          = beat_fire && (&beat_q);
  assign wr_tag_en_o     = last_o && !mem_d_denied_i;
  assign wr_tag_o.tag    = line_i.fields.tag;
  assign wr_tag_o.valid  = 1'b1;
  assign denied_o        = last_o && mem_d_denied_i;

endmodule

`default_nettype wire

// File: src/ic_storage.sv
// Per-way tag and data arrays with registered reads and write-to-read bypass
`default_nettype none
`include "icache_macros.svh"

module ic_storage (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   rd_req_i,
  input  wire icache_pkg::set_idx_t   rd_set_i,
  input  wire icache_pkg::beat_idx_t  rd_beat_i,
  input  wire icache_pkg::way_mask_t  wr_ways_i,
  input  wire icache_pkg::set_idx_t   wr_set_i,
  input  wire icache_pkg::beat_idx_t  wr_beat_i,
  input  wire logic                   wr_tag_en_i,
  input  wire logic                   wr_data_en_i,
  input  wire icache_pkg::tag_entry_t wr_tag_i,
  input  wire icache_pkg::dword_t     wr_data_i,
  output icache_pkg::tag_entry_t      rd_tags_o [1 << `IC_WAYS_WIDTH],
  output icache_pkg::dword_t          rd_data_o [1 << `IC_WAYS_WIDTH]
);
  import icache_pkg::*;

  localparam int unsigned NumWays  = 1 << `IC_WAYS_WIDTH;
  localparam int unsigned NumSets  = 1 << `IC_SETS_WIDTH;
  localparam int unsigned NumBeats = 1 << `IC_BEATS_WIDTH;

  logic tag_collide;
  logic data_collide;

  // Written value captured once, each way decides if it applies
  tag_entry_t tag_bypass_q;
  dword_t     data_bypass_q;

  assign tag_collide  = wr_tag_en_i && (wr_set_i == rd_set_i);
  assign data_collide = wr_data_en_i && (wr_set_i == rd_set_i) && (wr_beat_i == rd_beat_i);

  always_ff @(posedge clk_i) begin
    if (rd_req_i) begin
      tag_bypass_q  <= wr_tag_i;
      data_bypass_q <= wr_data_i;
    end
  end

  for (genvar w = 0; w < NumWays; w++) begin : g_way
    tag_entry_t tag_mem [NumSets];
    dword_t     data_mem [NumSets * NumBeats];
    tag_entry_t tag_raw_q;
    dword_t     data_raw_q;
    logic       tag_byp_q;
    logic       data_byp_q;

    always_ff @(posedge clk_i) begin
      if (wr_tag_en_i && wr_ways_i[w]) begin
        tag_mem[wr_set_i] <= wr_tag_i;
      end
      if (wr_data_en_i && wr_ways_i[w]) begin
        data_mem[{wr_set_i, wr_beat_i}] <= wr_data_i;
      end
      if (rd_req_i) begin
        tag_raw_q  <= tag_mem[rd_set_i];
        data_raw_q <= data_mem[{rd_set_i, rd_beat_i}];
      end
    end

    // Same-cycle write to the read location wins over the array
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        tag_byp_q  <= 1'b0;
        data_byp_q <= 1'b0;
      end else if (rd_req_i) begin
        tag_byp_q  <= tag_collide && wr_ways_i[w];
        data_byp_q <= data_collide && wr_ways_i[w];
      end
    end

    assign rd_tags_o[w] = tag_byp_q ? tag_bypass_q : tag_raw_q;
    assign rd_data_o[w] = data_byp_q ? data_bypass_q : data_raw_q;
  end

endmodule

`default_nettype wire

// File: src/ic_sweep.sv
// Set counter that invalidates every way after reset or on flush
`default_nettype none
`include "icache_macros.svh"

module ic_sweep (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   start_i,
  output icache_pkg::way_mask_t       wr_ways_o,
  output icache_pkg::set_idx_t        wr_set_o,
  output logic                        wr_tag_en_o,
  output icache_pkg::tag_entry_t      wr_tag_o,
  output logic                        busy_o,
  output logic                        done_o
);
  import icache_pkg::*;

  logic     busy_q;
  logic     done_q;
  set_idx_t set_q;

  // Comes out of reset already sweeping
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b1;
      done_q <= 1'b0;
      set_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        busy_q <= 1'b1;
        set_q  <= '0;
      end else if (busy_q) begin
        set_q <= set_q + 1'b1;
        if (&set_q) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  assign wr_ways_o   = '1;
  assign wr_set_o    = set_q;
  assign wr_tag_en_o = busy_q;
  assign wr_tag_o    = '0;
  assign busy_o      = busy_q;
  assign done_o      = done_q;

endmodule

`default_nettype wire

// File: src/ic_tag_match.sv
// Tag compare, hit vector, way choice and pseudo-FIFO victim pointer
`default_nettype none
`include "icache_macros.svh"

module ic_tag_match (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire icache_pkg::tag_entry_t tags_i [1 << `IC_WAYS_WIDTH],
  input  wire icache_pkg::ic_addr_u   addr_i,
  input  wire logic                   advance_i,
  output icache_pkg::way_mask_t       hit_o,
  output icache_pkg::way_idx_t        way_o
);
  import icache_pkg::*;

  localparam int unsigned NumWays = 1 << `IC_WAYS_WIDTH;

  way_idx_t fifo_ptr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fifo_ptr_q <= '0;
    end else if (advance_i) begin
      fifo_ptr_q <= fifo_ptr_q + 1'b1;
    end
  end

  // Priority: lowest hit, then lowest empty way, then FIFO pointer
  always_comb begin
    hit_o = '0;
    way_o = fifo_ptr_q;
    for (int i = NumWays - 1; i >= 0; i--) begin
      hit_o[i] = tags_i[i].valid && (tags_i[i].tag == addr_i.fields.tag);
      if (!tags_i[i].valid) begin
        way_o = way_idx_t'(i);
      end
    end
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (hit_o[i]) begin
        way_o = way_idx_t'(i);
      end
    end
  end

endmodule

`default_nettype wire

// File: src/icache_macros.svh
// Cache geometry and physical address width macros
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Four ways
`define IC_WAYS_WIDTH 2

// 64 sets
`define IC_SETS_WIDTH 6

`define IC_PADDR_LEN 32

// Eight 64-bit beats per line
`define IC_BEATS_WIDTH 3

// 64-byte lines
`define IC_LINE_OFFSET 6

`endif

// File: src/icache_pkg.sv
// Shared cache types, the fetch address union and the exception cause enum
`default_nettype none
`include "icache_macros.svh"

package icache_pkg;

  typedef logic [`IC_PADDR_LEN-1:0] paddr_t;

  typedef logic [`IC_SETS_WIDTH-1:0]         set_idx_t;
  typedef logic [`IC_BEATS_WIDTH-1:0]        beat_idx_t;
  typedef logic [`IC_WAYS_WIDTH-1:0]         way_idx_t;
  typedef logic [(1 << `IC_WAYS_WIDTH)-1:0]  way_mask_t;

  typedef logic [63:0] dword_t;
  typedef logic [31:0] instr_t;

  // Tag excludes set index and line offset bits
  typedef struct packed {
    logic [`IC_PADDR_LEN-`IC_SETS_WIDTH-`IC_LINE_OFFSET-1:0] tag;
    logic                                                    valid;
  } tag_entry_t;

  // One fetch address seen either as a raw word or as cache fields
  typedef union packed {
    paddr_t raw;
    struct packed {
      logic [`IC_PADDR_LEN-`IC_SETS_WIDTH-`IC_LINE_OFFSET-1:0] tag;
      set_idx_t                                                set_idx;
      beat_idx_t                                               beat_idx;
      logic                                                    half;
      logic [1:0]                                              byte_off;
    } fields;
  } ic_addr_u;

  typedef enum logic [3:0] {
    ExcNone             = 4'd0,
    ExcInstrAccessFault = 4'd1
  } exc_cause_e;

endpackage

`default_nettype wire

// File: src/icache_top.sv
// Instruction cache top with the stage wiring and the array write-port multiplexer
`default_nettype none
`include "icache_macros.svh"

module icache_top (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                req_valid_i,
  input  wire logic [63:0]         req_pc_i,
  input  wire logic                req_flush_i,
  output logic                     resp_valid_o,
  output icache_pkg::instr_t       resp_instr_o,
  output logic                     resp_exception_o,
  output icache_pkg::exc_cause_e   resp_ex_code_o,
  output logic                     mem_a_valid_o,
  input  wire logic                mem_a_ready_i,
  output icache_pkg::paddr_t       mem_a_address_o,
  input  wire logic                mem_d_valid_i,
  output logic                     mem_d_ready_o,
  input  wire icache_pkg::dword_t  mem_d_data_i,
  input  wire logic                mem_d_denied_i
);
  import icache_pkg::*;

  localparam int unsigned NumWays = 1 << `IC_WAYS_WIDTH;

  logic       rd_req;
  ic_addr_u   addr;
  tag_entry_t rd_tags [NumWays];
  dword_t     rd_data [NumWays];
  way_mask_t  hit;
  way_idx_t   way;
  logic       advance;
  logic       refill_start;
  logic       refill_holds;
  logic       refill_last;
  logic       refill_denied;
  logic       sweep_start;
  logic       sweep_busy;
  logic       sweep_done;

  // Refill and sweep write ports
  way_mask_t  ref_ways;
  set_idx_t   ref_set;
  beat_idx_t  ref_beat;
  logic       ref_tag_en;
  logic       ref_data_en;
  tag_entry_t ref_tag;
  dword_t     ref_data;
  way_mask_t  swp_ways;
  set_idx_t   swp_set;
  logic       swp_tag_en;
  tag_entry_t swp_tag;

  way_mask_t  wr_ways;
  set_idx_t   wr_set;
  beat_idx_t  wr_beat;
  logic       wr_tag_en;
  logic       wr_data_en;
  tag_entry_t wr_tag;

  //////////////////////////////////////////////////
  // Write port multiplexer
  //////////////////////////////////////////////////

  // Sweep owns the port unless a refill is in progress
  always_comb begin
    if (refill_holds) begin
      wr_ways    = ref_ways;
      wr_set     = ref_set;
      wr_beat    = ref_beat;
      wr_tag_en  = ref_tag_en;
      wr_data_en = ref_data_en;
      wr_tag     = ref_tag;
    end else begin
      wr_ways    = swp_ways;
      wr_set     = swp_set;
      wr_beat    = '0;
      wr_tag_en  = swp_tag_en;
      wr_data_en = 1'b0;
      wr_tag     = swp_tag;
    end
  end

  ic_fetch_ctrl ic_fetch_ctrl_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_valid_i      (req_valid_i),
    .req_pc_i         (req_pc_i),
    .req_flush_i      (req_flush_i),
    .hit_i            (hit),
    .way_i            (way),
    .rd_data_i        (rd_data),
    .sweep_done_i     (sweep_done),
    .sweep_busy_i     (sweep_busy),
    .mem_a_ready_i    (mem_a_ready_i),
    .refill_last_i    (refill_last),
    .refill_denied_i  (refill_denied),
    .resp_valid_o     (resp_valid_o),
    .resp_instr_o     (resp_instr_o),
    .resp_exception_o (resp_exception_o),
    .resp_ex_code_o   (resp_ex_code_o),
    .rd_req_o         (rd_req),
    .addr_o           (addr),
    .advance_o        (advance),
    .refill_start_o   (refill_start),
    .sweep_start_o    (sweep_start),
    .refill_holds_o   (refill_holds),
    .mem_a_valid_o    (mem_a_valid_o),
    .mem_a_address_o  (mem_a_address_o)
  );

  ic_storage ic_storage_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_req_i     (rd_req),
    .rd_set_i     (addr.fields.set_idx),
    .rd_beat_i    (addr.fields.beat_idx),
    .wr_ways_i    (wr_ways),
    .wr_set_i     (wr_set),
    .wr_beat_i    (wr_beat),
    .wr_tag_en_i  (wr_tag_en),
    .wr_data_en_i (wr_data_en),
    .wr_tag_i     (wr_tag),
    .wr_data_i    (ref_data),
    .rd_tags_o    (rd_tags),
    .rd_data_o    (rd_data)
  );

  ic_tag_match ic_tag_match_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .tags_i    (rd_tags),
    .addr_i    (addr),
    .advance_i (advance),
    .hit_o     (hit),
    .way_o     (way)
  );

  ic_refill ic_refill_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (refill_start),
    .line_i         (addr),
    .way_i          (way),
    .mem_d_valid_i  (mem_d_valid_i),
    .mem_d_data_i   (mem_d_data_i),
    .mem_d_denied_i (mem_d_denied_i),
    .mem_d_ready_o  (mem_d_ready_o),
    .wr_ways_o      (ref_ways),
    .wr_set_o       (ref_set),
    .wr_beat_o      (ref_beat),
    .wr_tag_en_o    (ref_tag_en),
    .wr_data_en_o   (ref_data_en),
    .wr_tag_o       (ref_tag),
    .wr_data_o      (ref_data),
    .last_o         (refill_last),
    .denied_o       (refill_denied)
  );

  ic_sweep ic_sweep_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (sweep_start),
    .wr_ways_o   (swp_ways),
    .wr_set_o    (swp_set),
    .wr_tag_en_o (swp_tag_en),
    .wr_tag_o    (swp_tag),
    .busy_o      (sweep_busy),
    .done_o      (sweep_done)
  );

endmodule

`default_nettype wire

// File: verif/tb_icache.sv
// Instruction cache testbench with random fetches, a reference model and compare tasks
`default_nettype none
`include "icache_macros.svh"

module tb_icache;
  import icache_pkg::*;

  localparam int unsigned Timeout = 2000;
  localparam int unsigned NumSets = 1 << `IC_SETS_WIDTH;
  localparam int unsigned NumWays = 1 << `IC_WAYS_WIDTH;
  localparam int unsigned NumRand = 300;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic        req_valid = 1'b0;
  logic [63:0] req_pc = '0;
  logic        req_flush = 1'b0;
  logic        resp_valid;
  instr_t      resp_instr;
  logic        resp_exception;
  exc_cause_e  resp_ex_code;
  logic        mem_a_valid;
  logic        mem_a_ready;
  paddr_t      mem_a_address;
  logic        mem_d_valid;
  logic        mem_d_ready;
  logic        mem_d_denied;
  dword_t      mem_d_data;
  logic [31:0] mem_req_count;

  // Reference model of the tag arrays and the victim pointer
  tag_entry_t  model_tags [NumSets][NumWays];
  way_idx_t    model_ptr;
  logic [31:0] rng;

  always #10 clk = ~clk;

  icache_top icache_top_i (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .req_valid_i      (req_valid),
    .req_pc_i         (req_pc),
    .req_flush_i      (req_flush),
    .resp_valid_o     (resp_valid),
    .resp_instr_o     (resp_instr),
    .resp_exception_o (resp_exception),
    .resp_ex_code_o   (resp_ex_code),
    .mem_a_valid_o    (mem_a_valid),
    .mem_a_ready_i    (mem_a_ready),
    .mem_a_address_o  (mem_a_address),
    .mem_d_valid_i    (mem_d_valid),
    .mem_d_ready_o    (mem_d_ready),
    .mem_d_data_i     (mem_d_data),
    .mem_d_denied_i   (mem_d_denied)
  );

  tb_icache_mem #(.Seed(32'h4096_b035)) mem_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .a_valid_i   (mem_a_valid),
    .a_address_i (mem_a_address),
    .a_ready_o   (mem_a_ready),
    .d_valid_o   (mem_d_valid),
    .d_ready_i   (mem_d_ready),
    .d_data_o    (mem_d_data),
    .d_denied_o  (mem_d_denied),
    .req_count_o (mem_req_count)
  );

  //////////////////////////////////////////////////
  // Stimulus helpers and reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [63:0] line_addr(input logic [19:0] tag, input set_idx_t idx);
    return {32'h0, tag, idx, 6'h00};
  endfunction

  // Instruction word from the beat hash with the odd slot in the upper half
  function automatic instr_t expected_instr(input logic [63:0] pc);
    paddr_t a;
    a = {pc[31:3], 3'b000};
    if (pc[2]) begin
      return a ^ 32'h9e37_79b9;
    end else begin
      return {a[15:0], a[31:16]} ^ 32'h5bd1_e995;
    end
  endfunction

  // Seven lines share set 5 so that random traffic keeps evicting
  function automatic logic [63:0] pool_pc(input logic [31:0] r);
    logic [63:0] pc;
    case (r[3:0])
      4'd0, 4'd13: pc = line_addr(20'h00001, 6'd5);
      4'd1, 4'd14: pc = line_addr(20'h00002, 6'd5);
      4'd2:        pc = line_addr(20'h00003, 6'd5);
      4'd3:        pc = line_addr(20'h00004, 6'd5);
      4'd4:        pc = line_addr(20'h00005, 6'd5);
      4'd5:        pc = line_addr(20'h00006, 6'd5);
      4'd6:        pc = line_addr(20'h00007, 6'd20);
      4'd7:        pc = line_addr(20'h00007, 6'd21);
      4'd8:        pc = line_addr(20'h0002b, 6'd20);
      4'd9:        pc = line_addr(20'h10003, 6'd5);
      4'd10:       pc = line_addr(20'h10005, 6'd30);
      4'd11:       pc = 64'h0000_0001_0000_0140;
      4'd12:       pc = 64'h0000_0000_8000_0180;
      default:     pc = line_addr(20'h002ab, 6'd40);
    endcase
    pc[5:2] = r[11:8];
    return pc;
  endfunction

  task automatic clear_model();
    for (int s = 0; s < NumSets; s++) begin
      for (int w = 0; w < NumWays; w++) begin
        model_tags[s][w] = '0;
      end
    end
  endtask

  task automatic predict_access(input logic [63:0] pc, input logic flush,
                                output logic miss, output logic exc);
    set_idx_t   idx;
    tag_entry_t entry;
    logic       found;
    int         way;
    miss = 1'b0;
    exc  = 1'b0;
    if (pc[63:31] != '0) begin
      exc = 1'b1;
    end else begin
      if (flush) begin
        clear_model();
      end
      idx         = pc[11:6];
      entry.tag   = pc[31:12];
      entry.valid = 1'b1;
      found       = 1'b0;
      for (int w = 0; w < NumWays; w++) begin
        if (model_tags[idx][w] == entry) begin
          found = 1'b1;
        end
      end
      if (!found) begin
        miss = 1'b1;
        way  = -1;
        for (int w = NumWays - 1; w >= 0; w--) begin
          if (!model_tags[idx][w].valid) begin
            way = w;
          end
        end
        if (way < 0) begin
          way = int'(model_ptr);
        end
        model_ptr = model_ptr + 2'd1;
        // A denied line is never installed
        if (pc[28]) begin
          exc = 1'b1;
        end else begin
          model_tags[idx][way] = entry;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_instr(input string name, input instr_t exp, input instr_t act);
    if (act !== exp) begin
      $display("Fail %s: expected instr %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_exc(input string name, input exc_cause_e exp, input exc_cause_e act);
    if (act !== exp) begin
      $display("Fail %s: expected cause %s, actual %s", name, exp.name(), act.name());
      abort_run();
    end
  endtask

  task automatic check_miss(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected memory request %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // Sends one request and checks its single response
  task automatic run_fetch(input string name, input logic [63:0] pc, input logic flush);
    logic        exp_miss;
    logic        exp_exc;
    paddr_t      exp_line;
    logic [31:0] count0;
    int unsigned waited;
    predict_access(pc, flush, exp_miss, exp_exc);
    exp_line = {pc[31:6], 6'h00};
    @(negedge clk);
    if (resp_valid) begin
      $display("A response appeared with no request outstanding before %s", name);
      abort_run();
    end
    count0    = mem_req_count;
    req_valid = 1'b1;
    req_pc    = pc;
    req_flush = flush;
    @(negedge clk);
    req_valid = 1'b0;
    req_flush = 1'b0;
    waited    = 1;
    while (!resp_valid) begin
      if (mem_a_valid && mem_a_address !== exp_line) begin
        $display("Fail %s: expected line address %h, actual %h", name, exp_line,
                 mem_a_address);
        abort_run();
      end
      if (waited >= Timeout) begin
        $display("No response to %s within %0d cycles", name, Timeout);
        abort_run();
      end
      @(negedge clk);
      waited++;
    end
    if (mem_req_count - count0 > 32'd1) begin
      $display("Fail %s: expected at most one memory request, actual %0d", name,
               mem_req_count - count0);
      abort_run();
    end
    check_exc(name, exp_exc ? ExcInstrAccessFault : ExcNone, resp_ex_code);
    if (resp_exception !== exp_exc) begin
      $display("Fail %s: expected exception flag %b, actual %b", name, exp_exc,
               resp_exception);
      abort_run();
    end
    if (!exp_exc) begin
      check_instr(name, expected_instr(pc), resp_instr);
    end
    check_miss(name, exp_miss, mem_req_count != count0);
    if (!exp_miss && waited != 1) begin
      $display("Fail %s: expected response after 1 cycle, actual %0d", name, waited);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    rng       = 32'h4096_b035;
    model_ptr = '0;
    clear_model();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // First request lands in the reset sweep, then misses
    run_fetch("cold_miss", line_addr(20'h00011, 6'd3) | 64'h14, 1'b0);
    run_fetch("warm_hit", line_addr(20'h00011, 6'd3) | 64'h2c, 1'b0);

    // Five lines in one set of four ways
    for (int i = 0; i < 5; i++) begin
      run_fetch($sformatf("evict_fill_%0d", i), line_addr(20'h00021 + 20'(i), 6'd9), 1'b0);
    end
    for (int i = 0; i < 5; i++) begin
      run_fetch($sformatf("evict_refetch_%0d", i),
                line_addr(20'h00021 + 20'(i), 6'd9) | 64'h3c, 1'b0);
    end

    run_fetch("denied_first", line_addr(20'h10044, 6'd12) | 64'h08, 1'b0);
    run_fetch("denied_again", line_addr(20'h10044, 6'd12) | 64'h10, 1'b0);
    run_fetch("non_canonical", 64'h0000_0010_0000_0200, 1'b0);

    run_fetch("flush", line_addr(20'h00011, 6'd3) | 64'h30, 1'b1);
    run_fetch("after_flush", line_addr(20'h00025, 6'd9), 1'b0);

    // Random pool traffic under memory back-pressure
    for (int i = 0; i < NumRand; i++) begin
      rng = xorshift32(rng);
      run_fetch($sformatf("random_%0d", i), pool_pc(rng), rng[15:12] == 4'h0);
    end

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/tb_icache_mem.sv
// Memory responder with hashed beat data, a denied region and random handshake gaps
`default_nettype none
`include "icache_macros.svh"

module tb_icache_mem #(
  parameter logic [31:0] Seed = 32'h4096_b035
) (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               a_valid_i,
  input  wire icache_pkg::paddr_t a_address_i,
  output logic                    a_ready_o,
  output logic                    d_valid_o,
  input  wire logic               d_ready_i,
  output icache_pkg::dword_t      d_data_o,
  output logic                    d_denied_o,
  output logic [31:0]             req_count_o
);
  import icache_pkg::*;

  logic [31:0] rng_q;
  logic        a_gap_q;
  logic        d_gap_q;
  logic        busy_q;
  beat_idx_t   beat_q;
  paddr_t      line_q;
  logic [31:0] count_q;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Upper word serves the odd instruction slot of a beat
  function automatic dword_t beat_data(input paddr_t a);
    return {a ^ 32'h9e37_79b9, {a[15:0], a[31:16]} ^ 32'h5bd1_e995};
  endfunction

  // Handshake gaps change on the falling edge
  always @(negedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rng_q   <= Seed;
      a_gap_q <= 1'b0;
      d_gap_q <= 1'b0;
    end else begin
      rng_q   <= xorshift32(rng_q);
      a_gap_q <= (rng_q[1:0] != 2'b00);
      d_gap_q <= (rng_q[3:2] != 2'b00);
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      beat_q  <= '0;
      line_q  <= '0;
      count_q <= '0;
    end else if (!busy_q) begin
      if (a_valid_i && a_ready_o) begin
        busy_q  <= 1'b1;
        beat_q  <= '0;
        line_q  <= a_address_i;
        count_q <= count_q + 32'd1;
      end
    end else if (d_valid_o && d_ready_i) begin
      beat_q <= beat_q + 3'd1;
      if (&beat_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Outputs stay low while reset is held
  assign a_ready_o   = rst_ni && !busy_q && a_gap_q;
  assign d_valid_o   = rst_ni && busy_q && d_gap_q;
  assign d_data_o    = rst_ni ? beat_data({line_q[31:6], beat_q, 3'b000}) : '0;
  assign d_denied_o  = rst_ni && line_q[28];
  assign req_count_o = count_q;

endmodule

`default_nettype wire
